//--- common/lc4_pkg.sv
// widths, opcodes, stall codes and the packed structs shared across the LC4 superscalar core
package lc4_pkg;

    localparam int XLEN      = 16;
    localparam int NREG_BITS = 3;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [NREG_BITS-1:0] reg_sel_t;

    // opcodes of the supported subset, insn[15:12]
    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_ARITH = 4'h1,  // ADD, SUB, ADD-immediate
        OP_LOGIC = 4'h5,  // AND only
        OP_LDR   = 4'h6,
        OP_STR   = 4'h7,
        OP_CONST = 4'h9
    } opcode_e;

    // retire stall codes, 2 (branch) is unused here
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_SPLIT = 2'd1,
        STALL_LOAD  = 2'd3
    } stall_e;

    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;       // store data register for STR
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        logic     is_load;
        logic     is_store;
    } ctrl_t;

    // one lane slot, operands are read in D and bypassed in X
    typedef struct packed {
        logic   valid;
        word_t  pc;
        word_t  insn;
        ctrl_t  ctrl;
        word_t  rs_data;
        word_t  rt_data;
        stall_e stall;
    } uop_t;

    typedef struct packed {
        logic     valid;
        logic     rd_we;
        reg_sel_t rd;
        word_t    data;
    } fwd_t;

    // all bypass sources, in priority order
    typedef struct packed {
        fwd_t mb;
        fwd_t ma;
        fwd_t wb;
        fwd_t wa;
    } fwd_set_t;

    typedef struct packed {
        reg_sel_t rs_a;
        reg_sel_t rt_a;
        reg_sel_t rs_b;
        reg_sel_t rt_b;
    } rsel_t;

    typedef struct packed {
        word_t rs_a;
        word_t rt_a;
        word_t rs_b;
        word_t rt_b;
    } rdata_t;

    typedef struct packed {
        logic  is_load;
        logic  is_store;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        logic     rd_we;
        reg_sel_t rd;
        word_t    wdata;
        logic     dmem_we;
        word_t    dmem_addr;
        stall_e   stall;
    } retire_t;

endpackage

//--- src/lc4_decoder.sv
// instruction decoder for the NOP/ADD/SUB/AND/ADDI/CONST/LDR/STR subset
module lc4_decoder (
    input  lc4_pkg::word_t i_insn,
    output lc4_pkg::ctrl_t o_ctrl
);
    import lc4_pkg::*;

    always_comb begin
        o_ctrl = '0;  // anything not listed below behaves as NOP
        case (opcode_e'(i_insn[15:12]))
            OP_ARITH: begin
                // MUL and DIV subops are not supported
                if (i_insn[5] || !i_insn[3]) begin
                    o_ctrl.rd    = i_insn[11:9];
                    o_ctrl.rs    = i_insn[8:6];
                    o_ctrl.rt    = i_insn[2:0];
                    o_ctrl.rs_re = 1'b1;
                    o_ctrl.rt_re = !i_insn[5];  // immediate form has no rt
                    o_ctrl.rd_we = 1'b1;
                end
            end
            OP_LOGIC: begin
                if (i_insn[5:3] == 3'b000) begin
                    o_ctrl.rd    = i_insn[11:9];
                    o_ctrl.rs    = i_insn[8:6];
                    o_ctrl.rt    = i_insn[2:0];
                    o_ctrl.rs_re = 1'b1;
                    o_ctrl.rt_re = 1'b1;
                    o_ctrl.rd_we = 1'b1;
                end
            end
            OP_LDR: begin
                o_ctrl.rd      = i_insn[11:9];
                o_ctrl.rs      = i_insn[8:6];
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd_we   = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            OP_STR: begin
                o_ctrl.rt       = i_insn[11:9];  // data to store
                o_ctrl.rs       = i_insn[8:6];   // base address
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            OP_CONST: begin
                o_ctrl.rd    = i_insn[11:9];
                o_ctrl.rd_we = 1'b1;
            end
            OP_NOP:  ;
            default: ;
        endcase
    end

    // the memory arbiter relies on one access kind per instruction
    always_comb begin
        assert (!(o_ctrl.is_load && o_ctrl.is_store))
            else $error("decoder flags both load and store for %h", i_insn);
    end

endmodule

//--- src/lc4_alu.sv
// ALU for the arithmetic, immediate, CONST and load/store address operations
module lc4_alu (
    input  lc4_pkg::word_t i_insn,
    input  lc4_pkg::word_t i_rs,
    input  lc4_pkg::word_t i_rt,
    output lc4_pkg::word_t o_result
);
    import lc4_pkg::*;

    word_t imm5, imm6, imm9;

    assign imm5 = {{(XLEN-5){i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{(XLEN-6){i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{(XLEN-9){i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        case (opcode_e'(i_insn[15:12]))
            OP_ARITH: begin
                if (i_insn[5])      o_result = i_rs + imm5;
                else if (i_insn[4]) o_result = i_rs - i_rt;
                else                o_result = i_rs + i_rt;
            end
            OP_LOGIC:        o_result = i_rs & i_rt;
            OP_LDR, OP_STR:  o_result = i_rs + imm6;  // effective address
            OP_CONST:        o_result = imm9;
            default:         o_result = '0;
        endcase
    end

endmodule

//--- src/lc4_regfile_ss.sv
// eight-entry register file, four read ports, two write ports, write-through reads
module lc4_regfile_ss (
    input  logic              gwe,
    input  logic              i_rst_n,
    input  lc4_pkg::reg_sel_t i_rs_a,
    input  lc4_pkg::reg_sel_t i_rt_a,
    input  lc4_pkg::reg_sel_t i_rs_b,
    input  lc4_pkg::reg_sel_t i_rt_b,
    input  lc4_pkg::fwd_t     i_wr_a,
    input  lc4_pkg::fwd_t     i_wr_b,
    output lc4_pkg::word_t    o_rs_data_a,
    output lc4_pkg::word_t    o_rt_data_a,
    output lc4_pkg::word_t    o_rs_data_b,
    output lc4_pkg::word_t    o_rt_data_b
);
    import lc4_pkg::*;

    word_t regs [2**NREG_BITS];
    logic  we_a, we_b;

    assign we_a = i_wr_a.valid && i_wr_a.rd_we;
    assign we_b = i_wr_b.valid && i_wr_b.rd_we;

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**NREG_BITS; i++) regs[i] <= '0;
        end else begin
            if (we_a) regs[i_wr_a.rd] <= i_wr_a.data;
            if (we_b) regs[i_wr_b.rd] <= i_wr_b.data;  // lane B is younger, wins a tie
        end
    end

    // same-cycle writes are visible to D-stage reads
    function automatic word_t read_port(input reg_sel_t sel);
        if (we_b && i_wr_b.rd == sel) return i_wr_b.data;
        if (we_a && i_wr_a.rd == sel) return i_wr_a.data;
        return regs[sel];
    endfunction

    always_comb begin
        o_rs_data_a = read_port(i_rs_a);
        o_rt_data_a = read_port(i_rt_a);
        o_rs_data_b = read_port(i_rs_b);
        o_rt_data_b = read_port(i_rt_b);
    end

endmodule

//--- issue/lc4_issue.sv
// fetch PC, decode pair register, pair split and load-use stall logic
module lc4_issue #(
    parameter lc4_pkg::word_t PC_RESET = 16'h8200
) (
    input  logic            gwe,
    input  logic            i_rst_n,
    input  lc4_pkg::word_t  i_insn_a,
    input  lc4_pkg::word_t  i_insn_b,
    input  lc4_pkg::uop_t   i_x_a,
    input  lc4_pkg::uop_t   i_x_b,
    output lc4_pkg::word_t  o_pc,
    output lc4_pkg::rsel_t  o_rsel,
    input  lc4_pkg::rdata_t i_rdata,
    output lc4_pkg::uop_t   o_issue_a,
    output lc4_pkg::uop_t   o_issue_b
);
    import lc4_pkg::*;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        word_t  insn;
        stall_e stall;
    } dslot_t;

    word_t  pc_q;
    dslot_t d_a, d_b;
    ctrl_t  ctrl_a, ctrl_b;
    logic   ldu_a, ldu_b, b_needs_a, both_mem, split;
    stall_e b_hold;  // why B could not go with A

    lc4_decoder u_dec_a (.i_insn(d_a.insn), .o_ctrl(ctrl_a));
    lc4_decoder u_dec_b (.i_insn(d_b.insn), .o_ctrl(ctrl_b));

    // store data is not checked, it gets WM bypass later
    function automatic logic load_use(input uop_t x, input ctrl_t c);
        return x.valid && x.ctrl.is_load &&
               ((c.rs_re && c.rs == x.ctrl.rd) ||
                (c.rt_re && !c.is_store && c.rt == x.ctrl.rd));
    endfunction

    assign ldu_a = d_a.valid && (load_use(i_x_a, ctrl_a) || load_use(i_x_b, ctrl_a));
    assign ldu_b = d_b.valid && (load_use(i_x_a, ctrl_b) || load_use(i_x_b, ctrl_b));

    assign b_needs_a = ctrl_a.rd_we &&
                       ((ctrl_b.rs_re && ctrl_b.rs == ctrl_a.rd) ||
                        (ctrl_b.rt_re && ctrl_b.rt == ctrl_a.rd));
    assign both_mem  = (ctrl_a.is_load || ctrl_a.is_store) &&
                       (ctrl_b.is_load || ctrl_b.is_store);
    assign split     = d_a.valid && d_b.valid && (b_needs_a || both_mem || ldu_b);
    assign b_hold    = (b_needs_a || both_mem) ? STALL_SPLIT : STALL_LOAD;

    assign o_pc   = pc_q;
    assign o_rsel = '{rs_a: ctrl_a.rs, rt_a: ctrl_a.rt, rs_b: ctrl_b.rs, rt_b: ctrl_b.rt};

    always_comb begin
        o_issue_a = '{valid: d_a.valid && !ldu_a, pc: d_a.pc, insn: d_a.insn, ctrl: ctrl_a,
                      rs_data: i_rdata.rs_a, rt_data: i_rdata.rt_a,
                      stall: ldu_a ? STALL_LOAD : d_a.stall};
        o_issue_b = '{valid: d_b.valid && !ldu_a && !split, pc: d_b.pc, insn: d_b.insn,
                      ctrl: ctrl_b, rs_data: i_rdata.rs_b, rt_data: i_rdata.rt_b,
                      stall: d_b.stall};
        if (ldu_a)      o_issue_b.stall = STALL_LOAD;
        else if (split) o_issue_b.stall = b_hold;
    end

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= PC_RESET;
            d_a  <= '0;
            d_b  <= '0;
        end else if (ldu_a) begin
            d_a.stall <= STALL_LOAD;  // whole pair holds, pc too
            d_b.stall <= STALL_LOAD;
        end else if (split) begin
            // B slides into slot A, slot B takes the first fetched insn
            d_a  <= '{valid: d_b.valid, pc: d_b.pc, insn: d_b.insn, stall: b_hold};
            d_b  <= '{valid: 1'b1, pc: pc_q, insn: i_insn_a, stall: STALL_NONE};
            pc_q <= pc_q + word_t'(1);
        end else begin
            d_a  <= '{valid: 1'b1, pc: pc_q, insn: i_insn_a, stall: STALL_NONE};
            d_b  <= '{valid: 1'b1, pc: pc_q + word_t'(1), insn: i_insn_b, stall: STALL_NONE};
            pc_q <= pc_q + word_t'(2);
        end
    end

    // what was issued last cycle sits in the lanes' X registers now
    a_one_mem_in_x: assert property (@(posedge gwe) disable iff (!i_rst_n)
        !(i_x_a.valid && i_x_b.valid &&
          (i_x_a.ctrl.is_load || i_x_a.ctrl.is_store) &&
          (i_x_b.ctrl.is_load || i_x_b.ctrl.is_store)));

endmodule

//--- lane/lc4_lane.sv
// one pipeline lane: X, M and W registers, bypass muxes, memory request and retire trace
module lc4_lane (
    input  logic              gwe,
    input  logic              i_rst_n,
    input  lc4_pkg::uop_t     i_issue,
    input  lc4_pkg::fwd_set_t i_fwd,
    input  lc4_pkg::word_t    i_mem_rdata,
    output lc4_pkg::uop_t     o_x,
    output lc4_pkg::fwd_t     o_fwd_m,
    output lc4_pkg::fwd_t     o_fwd_w,
    output lc4_pkg::mem_req_t o_mem_req,
    output lc4_pkg::retire_t  o_retire
);
    import lc4_pkg::*;

    uop_t  x_q, m_q, w_q;
    word_t x_rs, x_rt, x_alu;
    word_t m_alu, m_st_data;
    word_t w_alu, w_load, w_data;
    logic  x_reads_m_load;

    function automatic logic fwd_hit(input fwd_t f, input reg_sel_t sel);
        return f.valid && f.rd_we && (f.rd == sel);
    endfunction

    // MX then WX, lane B ahead of lane A within a stage
    function automatic word_t mx_wx(input reg_sel_t sel, input word_t rf_data);
        if (fwd_hit(i_fwd.mb, sel)) return i_fwd.mb.data;
        if (fwd_hit(i_fwd.ma, sel)) return i_fwd.ma.data;
        if (fwd_hit(i_fwd.wb, sel)) return i_fwd.wb.data;
        if (fwd_hit(i_fwd.wa, sel)) return i_fwd.wa.data;
        return rf_data;
    endfunction

    always_comb begin
        x_rs = mx_wx(x_q.ctrl.rs, x_q.rs_data);
        x_rt = mx_wx(x_q.ctrl.rt, x_q.rt_data);
        // WM, covers a load feeding the data of the next store
        if (fwd_hit(i_fwd.wb, m_q.ctrl.rt))      m_st_data = i_fwd.wb.data;
        else if (fwd_hit(i_fwd.wa, m_q.ctrl.rt)) m_st_data = i_fwd.wa.data;
        else                                      m_st_data = m_q.rt_data;
    end

    lc4_alu u_alu (.i_insn(x_q.insn), .i_rs(x_rs), .i_rt(x_rt), .o_result(x_alu));

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            x_q <= '0;
            m_q <= '0;
            w_q <= '0;
        end else begin
            x_q         <= i_issue;
            m_q         <= x_q;
            m_q.rt_data <= x_rt;  // store data after MX/WX
            w_q         <= m_q;
        end
    end

    always_ff @(posedge gwe) begin
        m_alu  <= x_alu;
        w_alu  <= m_alu;
        w_load <= i_mem_rdata;
    end

    assign w_data = w_q.ctrl.is_load ? w_load : w_alu;

    assign o_x       = x_q;
    assign o_fwd_m   = '{valid: m_q.valid, rd_we: m_q.ctrl.rd_we && !m_q.ctrl.is_load,
                         rd: m_q.ctrl.rd, data: m_alu};  // load data not ready in M
    assign o_fwd_w   = '{valid: w_q.valid, rd_we: w_q.ctrl.rd_we, rd: w_q.ctrl.rd, data: w_data};
    assign o_mem_req = '{is_load: m_q.valid && m_q.ctrl.is_load,
                         is_store: m_q.valid && m_q.ctrl.is_store,
                         addr: m_alu, wdata: m_st_data};

    assign o_retire = '{valid: w_q.valid, pc: w_q.pc, insn: w_q.insn,
                        rd_we: w_q.valid && w_q.ctrl.rd_we, rd: w_q.ctrl.rd, wdata: w_data,
                        dmem_we: w_q.valid && w_q.ctrl.is_store,
                        dmem_addr: (w_q.ctrl.is_load || w_q.ctrl.is_store) ? w_alu : '0,
                        stall: w_q.stall};

    // issue holds back any reader of a load still in M
    assign x_reads_m_load = m_q.valid && m_q.ctrl.is_load && x_q.valid &&
                            ((x_q.ctrl.rs_re && x_q.ctrl.rs == m_q.ctrl.rd) ||
                             (x_q.ctrl.rt_re && !x_q.ctrl.is_store && x_q.ctrl.rt == m_q.ctrl.rd));

    a_no_load_use: assert property (@(posedge gwe) disable iff (!i_rst_n) !x_reads_m_load);

endmodule

//--- src/lc4_dmem_arbiter.sv
// steering of the single data-memory port between the two M stages
module lc4_dmem_arbiter (
    input  lc4_pkg::mem_req_t i_req_a,
    input  lc4_pkg::mem_req_t i_req_b,
    input  lc4_pkg::word_t    i_rdata,
    output lc4_pkg::word_t    o_addr,
    output logic              o_we,
    output lc4_pkg::word_t    o_wdata,
    output lc4_pkg::word_t    o_rdata_a,
    output lc4_pkg::word_t    o_rdata_b
);
    import lc4_pkg::*;

    logic act_a, act_b;

    assign act_a = i_req_a.is_load || i_req_a.is_store;
    assign act_b = i_req_b.is_load || i_req_b.is_store;

    always_comb begin
        o_addr    = '0;  // idle port shows zeros
        o_we      = 1'b0;
        o_wdata   = '0;
        o_rdata_a = '0;
        o_rdata_b = '0;
        if (act_a) begin
            o_addr    = i_req_a.addr;
            o_we      = i_req_a.is_store;
            o_wdata   = i_req_a.wdata;
            o_rdata_a = i_rdata;
        end else if (act_b) begin
            o_addr    = i_req_b.addr;
            o_we      = i_req_b.is_store;
            o_wdata   = i_req_b.wdata;
            o_rdata_b = i_rdata;
        end
    end

    // pair split in issue keeps the two M stages from colliding
    always_comb begin
        assert (!(act_a && act_b)) else $error("both lanes access data memory at once");
    end

endmodule

//--- src/lc4_processor_ss.sv
// two-lane superscalar LC4 core: issue, two lanes, register file and data-memory arbiter
module lc4_processor_ss #(
    parameter lc4_pkg::word_t PC_RESET = 16'h8200
) (
    input  logic             gwe,
    input  logic             i_rst_n,
    output lc4_pkg::word_t   o_cur_pc,
    input  lc4_pkg::word_t   i_cur_insn_a,    // imem at o_cur_pc
    input  lc4_pkg::word_t   i_cur_insn_b,    // imem at o_cur_pc+1
    output lc4_pkg::word_t   o_dmem_addr,
    output logic             o_dmem_we,
    output lc4_pkg::word_t   o_dmem_towrite,
    input  lc4_pkg::word_t   i_dmem_rdata,
    output lc4_pkg::retire_t o_retire_a,
    output lc4_pkg::retire_t o_retire_b
);
    import lc4_pkg::*;

    rsel_t    rsel;
    rdata_t   rdata;
    uop_t     issue_a, issue_b, x_a, x_b;
    fwd_t     fwd_ma, fwd_wa, fwd_mb, fwd_wb;
    fwd_set_t fwd_all;
    mem_req_t req_a, req_b;
    word_t    mem_rdata_a, mem_rdata_b;

    assign fwd_all = '{mb: fwd_mb, ma: fwd_ma, wb: fwd_wb, wa: fwd_wa};

    lc4_issue #(.PC_RESET(PC_RESET)) u_issue (
        .gwe(gwe), .i_rst_n(i_rst_n),
        .i_insn_a(i_cur_insn_a), .i_insn_b(i_cur_insn_b),
        .i_x_a(x_a), .i_x_b(x_b),
        .o_pc(o_cur_pc), .o_rsel(rsel), .i_rdata(rdata),
        .o_issue_a(issue_a), .o_issue_b(issue_b)
    );

    lc4_regfile_ss u_regfile (
        .gwe(gwe), .i_rst_n(i_rst_n),
        .i_rs_a(rsel.rs_a), .i_rt_a(rsel.rt_a), .i_rs_b(rsel.rs_b), .i_rt_b(rsel.rt_b),
        .i_wr_a(fwd_wa), .i_wr_b(fwd_wb),
        .o_rs_data_a(rdata.rs_a), .o_rt_data_a(rdata.rt_a),
        .o_rs_data_b(rdata.rs_b), .o_rt_data_b(rdata.rt_b)
    );

    lc4_lane u_lane_a (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_issue(issue_a), .i_fwd(fwd_all),
        .i_mem_rdata(mem_rdata_a), .o_x(x_a), .o_fwd_m(fwd_ma), .o_fwd_w(fwd_wa),
        .o_mem_req(req_a), .o_retire(o_retire_a)
    );

    lc4_lane u_lane_b (
        .gwe(gwe), .i_rst_n(i_rst_n), .i_issue(issue_b), .i_fwd(fwd_all),
        .i_mem_rdata(mem_rdata_b), .o_x(x_b), .o_fwd_m(fwd_mb), .o_fwd_w(fwd_wb),
        .o_mem_req(req_b), .o_retire(o_retire_b)
    );

    lc4_dmem_arbiter u_dmem_arb (
        .i_req_a(req_a), .i_req_b(req_b), .i_rdata(i_dmem_rdata),
        .o_addr(o_dmem_addr), .o_we(o_dmem_we), .o_wdata(o_dmem_towrite),
        .o_rdata_a(mem_rdata_a), .o_rdata_b(mem_rdata_b)
    );

endmodule

//--- verif/lc4_mem_model.sv
// simulation instruction and data memories with preload tasks
module lc4_mem_model (
    input  logic           gwe,
    input  lc4_pkg::word_t i_pc,
    output lc4_pkg::word_t o_insn_a,
    output lc4_pkg::word_t o_insn_b,
    input  lc4_pkg::word_t i_dmem_addr,
    input  logic           i_dmem_we,
    input  lc4_pkg::word_t i_dmem_wdata,
    output lc4_pkg::word_t o_dmem_rdata
);
    import lc4_pkg::*;

    word_t imem [2**XLEN];
    word_t dmem [2**XLEN];

    assign o_insn_a     = imem[i_pc];
    assign o_insn_b     = imem[i_pc + word_t'(1)];  // second slot of the fetch pair
    assign o_dmem_rdata = dmem[i_dmem_addr];        // read answers within the M cycle

    always @(posedge gwe) begin
        if (i_dmem_we) dmem[i_dmem_addr] <= i_dmem_wdata;
    end

    // opcode 0 everywhere, low bits tagged with the address
    task automatic fill_imem();
        for (int i = 0; i < 2**XLEN; i++) begin
            imem[i] = {4'h0, 12'(i >> 4) ^ 12'(i)};
        end
    endtask

    task automatic fill_dmem();
        for (int i = 0; i < 2**XLEN; i++) begin
            dmem[i] <= word_t'(i) ^ 16'h5a5a;
        end
    endtask

    task automatic load_insn(input word_t addr, input word_t insn);
        imem[addr] = insn;
    endtask

    task automatic load_data(input word_t addr, input word_t data);
        dmem[addr] <= data;
    endtask

    initial begin
        fill_imem();
        fill_dmem();
    end

endmodule

//--- verif/tb_lc4_ss.sv
// testbench for the superscalar LC4 core: clock, reset, watchdog, reference model, directed tests
module tb_lc4_ss;
    import lc4_pkg::*;

    localparam word_t PC_RESET      = 16'h8200;
    localparam int    CLK_PERIOD    = 4;
    localparam int    NUM_TESTS     = 5;
    localparam int    TEST_CYCLES   = 30;  // reset plus the longest program and its stalls
    localparam int    MARGIN_CYCLES = 50;

    logic    gwe;
    logic    rst_n;
    word_t   cur_pc, insn_a, insn_b;
    word_t   dmem_addr, dmem_wdata, dmem_rdata;
    logic    dmem_we;
    retire_t retire_a, retire_b;

    word_t   ref_regs [8];
    word_t   ref_mem [word_t];  // preloaded and stored words only
    retire_t log_q [$];         // retired instructions, oldest first
    int      cyc_q [$];         // cycle of each entry in log_q
    int      cyc = 0;
    int      rel_cyc;           // cycle in which PC_RESET is first fetched
    int      errors = 0;
    int      we_count = 0;
    word_t   we_addr, we_data;

    lc4_processor_ss #(.PC_RESET(PC_RESET)) dut (
        .gwe(gwe), .i_rst_n(rst_n),
        .o_cur_pc(cur_pc), .i_cur_insn_a(insn_a), .i_cur_insn_b(insn_b),
        .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_towrite(dmem_wdata),
        .i_dmem_rdata(dmem_rdata), .o_retire_a(retire_a), .o_retire_b(retire_b)
    );

    lc4_mem_model u_mem (
        .gwe(gwe), .i_pc(cur_pc), .o_insn_a(insn_a), .o_insn_b(insn_b),
        .i_dmem_addr(dmem_addr), .i_dmem_we(dmem_we), .i_dmem_wdata(dmem_wdata),
        .o_dmem_rdata(dmem_rdata)
    );

    initial begin
        gwe = 1'b0;
        forever #(CLK_PERIOD / 2) gwe = ~gwe;
    end

    always @(posedge gwe) cyc <= cyc + 1;

    initial begin
        #(CLK_PERIOD * (NUM_TESTS * TEST_CYCLES + MARGIN_CYCLES));
        $display("timeout: the directed tests did not finish in time");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    function automatic word_t const_insn(input reg_sel_t rd, input logic [8:0] imm);
        return {4'h9, rd, imm};
    endfunction

    function automatic word_t add_insn(input reg_sel_t rd, input reg_sel_t rs, input reg_sel_t rt);
        return {4'h1, rd, rs, 3'b000, rt};
    endfunction

    function automatic word_t ldr_insn(input reg_sel_t rd, input reg_sel_t rs, input logic [5:0] off);
        return {4'h6, rd, rs, off};
    endfunction

    function automatic word_t str_insn(input reg_sel_t rt, input reg_sel_t rs, input logic [5:0] off);
        return {4'h7, rt, rs, off};
    endfunction

    // ISA result of one retired instruction, then the reference state moves on
    task automatic check_retire(input retire_t r);
        word_t    exp_pc, insn, rs_v, rt_v, addr, exp;
        reg_sel_t rd;
        logic     wr, st, mem;
        if (!r.valid) return;
        exp_pc = PC_RESET + word_t'(log_q.size());  // program order, lane A first
        insn   = u_mem.imem[exp_pc];
        assert (r.pc == exp_pc && r.insn == insn)
            else report_error($sformatf("retired pc %h insn %h, expected pc %h insn %h",
                                        r.pc, r.insn, exp_pc, insn));
        rd   = insn[11:9];
        rs_v = ref_regs[insn[8:6]];
        rt_v = ref_regs[insn[2:0]];
        addr = rs_v + {{10{insn[5]}}, insn[5:0]};
        wr   = 1'b1;
        st   = 1'b0;
        mem  = 1'b0;
        exp  = '0;
        case (insn[15:12])
            4'h1: begin
                if (insn[5])                  exp = rs_v + {{11{insn[4]}}, insn[4:0]};
                else if (insn[5:3] == 3'b010) exp = rs_v - rt_v;
                else                          exp = rs_v + rt_v;
            end
            4'h5: exp = rs_v & rt_v;
            4'h6: begin
                mem = 1'b1;
                assert (ref_mem.exists(addr))
                    else report_error($sformatf("pc %h loads unknown address %h", r.pc, addr));
                exp = ref_mem[addr];
            end
            4'h7: begin
                wr  = 1'b0;
                st  = 1'b1;
                mem = 1'b1;
            end
            4'h9: exp = {{7{insn[8]}}, insn[8:0]};
            default: wr = 1'b0;  // NOP filler
        endcase
        assert (r.rd_we == wr && r.dmem_we == st)
            else report_error($sformatf("pc %h flags rd_we=%b dmem_we=%b, expected %b %b",
                                        r.pc, r.rd_we, r.dmem_we, wr, st));
        if (wr) begin
            assert (r.rd == rd && r.wdata == exp)
                else report_error($sformatf("pc %h wrote R%0d=%h, expected R%0d=%h",
                                            r.pc, r.rd, r.wdata, rd, exp));
            ref_regs[rd] = exp;
        end
        if (mem) begin
            assert (r.dmem_addr == addr)
                else report_error($sformatf("pc %h memory address %h, expected %h",
                                            r.pc, r.dmem_addr, addr));
        end
        if (st) ref_mem[addr] = ref_regs[rd];
        log_q.push_back(r);
        cyc_q.push_back(cyc);
    endtask

    always @(negedge gwe) begin
        if (dmem_we) begin
            we_count++;
            we_addr = dmem_addr;
            we_data = dmem_wdata;
        end
        check_retire(retire_a);  // lane A is the older one
        check_retire(retire_b);
    end

    task automatic start_test();
        @(posedge gwe);
        rst_n <= 1'b0;
        u_mem.fill_imem();
        foreach (ref_regs[i]) ref_regs[i] = '0;
        log_q.delete();
        cyc_q.delete();
        we_count = 0;
    endtask

    task automatic put_insn(input int idx, input word_t insn);
        u_mem.load_insn(PC_RESET + word_t'(idx), insn);
    endtask

    task automatic preload_data(input word_t addr, input word_t data);
        u_mem.load_data(addr, data);
        ref_mem[addr] = data;
    endtask

    // five cycles in reset, all quiet, then release
    task automatic release_reset();
        repeat (5) begin
            @(negedge gwe);
            assert (!retire_a.valid && !retire_b.valid && !dmem_we && cur_pc == PC_RESET)
                else report_error("core not idle at PC_RESET while reset is held");
        end
        @(posedge gwe);
        rst_n <= 1'b1;
        @(negedge gwe);
        rel_cyc = cyc;
    endtask

    task automatic wait_retired(input int n);
        while (log_q.size() < n) @(posedge gwe);
    endtask

    task automatic check_entry(input int idx, input stall_e stall, input int dly,
                               input logic chk_data, input word_t wdata);
        retire_t r;
        r = log_q[idx];
        assert (r.pc == PC_RESET + word_t'(idx))
            else report_error($sformatf("retire %0d has pc %h", idx, r.pc));
        assert (r.stall == stall)
            else report_error($sformatf("pc %h stall %0d, expected %0d", r.pc, r.stall, stall));
        assert (cyc_q[idx] == rel_cyc + dly)
            else report_error($sformatf("pc %h retired after %0d cycles, expected %0d",
                                        r.pc, cyc_q[idx] - rel_cyc, dly));
        if (chk_data) begin
            assert (r.wdata == wdata)
                else report_error($sformatf("pc %h wdata %h, expected %h", r.pc, r.wdata, wdata));
        end
    endtask

    task automatic test_reset();
        start_test();
        release_reset();
        assert (cur_pc == PC_RESET) else report_error($sformatf("first fetch pc %h", cur_pc));
        for (int k = 0; k < 4; k++) begin
            if (k > 0) @(negedge gwe);
            assert (!retire_a.valid && !retire_b.valid && !dmem_we)
                else report_error("retire or store seen before anything reached writeback");
        end
    endtask

    task automatic test_independent_pair();
        start_test();
        put_insn(0, const_insn(3'd1, 9'd5));
        put_insn(1, const_insn(3'd2, 9'h1fd));  // -3
        release_reset();
        wait_retired(2);
        check_entry(0, STALL_NONE, 4, 1'b1, 16'h0005);
        check_entry(1, STALL_NONE, 4, 1'b1, 16'hfffd);
    endtask

    task automatic test_dependent_pair();
        start_test();
        put_insn(0, const_insn(3'd1, 9'd7));
        put_insn(1, add_insn(3'd2, 3'd1, 3'd1));  // needs R1 from lane A
        release_reset();
        wait_retired(2);
        check_entry(0, STALL_NONE, 4, 1'b1, 16'h0007);
        check_entry(1, STALL_SPLIT, 5, 1'b1, 16'h000e);
    endtask

    // slots 1, 3 and 5 keep the NOP filler
    task automatic test_load_use();
        start_test();
        preload_data(16'h0040, 16'h1234);
        put_insn(0, const_insn(3'd3, 9'h040));
        put_insn(2, ldr_insn(3'd4, 3'd3, 6'd0));
        put_insn(4, add_insn(3'd5, 3'd4, 3'd4));
        release_reset();
        wait_retired(5);
        check_entry(2, STALL_NONE, 5, 1'b1, 16'h1234);
        check_entry(4, STALL_LOAD, 7, 1'b1, 16'h2468);
    endtask

    task automatic test_shared_mem_port();
        start_test();
        put_insn(0, const_insn(3'd1, 9'h050));
        put_insn(1, const_insn(3'd2, 9'h0ab));
        put_insn(2, str_insn(3'd2, 3'd1, 6'd0));
        put_insn(3, ldr_insn(3'd3, 3'd1, 6'd0));
        release_reset();
        wait_retired(4);
        check_entry(2, STALL_NONE, 5, 1'b0, '0);
        check_entry(3, STALL_SPLIT, 6, 1'b1, 16'h00ab);
        assert (we_count == 1 && we_addr == 16'h0050 && we_data == ref_mem[16'h0050]
                && we_data == 16'h00ab)
            else report_error($sformatf("%0d dmem writes, last %h to %h", we_count,
                                        we_data, we_addr));
    endtask

    initial begin
        rst_n = 1'b0;
        test_reset();
        test_independent_pair();
        test_dependent_pair();
        test_load_use();
        test_shared_mem_port();
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- lc4_ss.f
common/lc4_pkg.sv
src/lc4_decoder.sv
src/lc4_alu.sv
src/lc4_regfile_ss.sv
issue/lc4_issue.sv
lane/lc4_lane.sv
src/lc4_dmem_arbiter.sv
src/lc4_processor_ss.sv
verif/lc4_mem_model.sv
verif/tb_lc4_ss.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_lc4_ss -f lc4_ss.f -o tb_lc4_ss \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_lc4_ss > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
